//--- hdl/flow_pkg.sv
package flow_pkg;

   // default geometry of the data flow bus
   localparam int DEF_DATA_W  = 32;
   localparam int DEF_N_LANES = 8;

   // bits needed to index one lane
   localparam int lane_sel_w = $clog2(DEF_N_LANES);

   typedef logic [lane_sel_w-1:0] lane_sel_t;

   // one data word on a lane
   typedef logic [DEF_DATA_W-1:0] flow_word_t;

   // whole bus, lane 0 in the low bits
   typedef flow_word_t [DEF_N_LANES-1:0] flow_bus_t;

endpackage

//--- hdl/muladd_pkg.sv
package muladd_pkg;

   localparam int OPCODE_W   = 4;
   localparam int PERIOD_W   = 16;   // delay and iteration counters
   localparam int WB_ADR_W   = 2;
   localparam int WB_DAT_W   = 32;
   localparam int PIPE_DEPTH = 2;    // multiplier latency

   typedef enum logic [OPCODE_W-1:0] {
      MUL_DIV2     = 4'd0,
      MUL          = 4'd1,
      MACC_DIV2    = 4'd2,
      MSUB_DIV2    = 4'd3,
      MACC         = 4'd4,
      MACC_16Q16   = 4'd5,
      MSUB         = 4'd6,
      MUL_LOW      = 4'd7,
      MUL_LOW_MACC = 4'd8,
      MACC_PLAIN   = 4'd9    // also taken by any unused code
   } opcode_e;

   typedef enum logic [1:0] {IDLE, WAIT, RUN, DRAIN} run_state_e;

   typedef struct packed {
      flow_pkg::lane_sel_t  sela;
      flow_pkg::lane_sel_t  selb;
      flow_pkg::lane_sel_t  selo;
      opcode_e              opcode;
      logic [PERIOD_W-1:0]  delay;
      logic [PERIOD_W-1:0]  iterations;
   } muladd_conf_t;

   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [WB_ADR_W-1:0] adr;
      logic [WB_DAT_W-1:0] dat;
   } wb_req_t;

   // register addresses
   localparam logic [WB_ADR_W-1:0] REG_CONF  = 2'd0;
   localparam logic [WB_ADR_W-1:0] REG_DELAY = 2'd1;
   localparam logic [WB_ADR_W-1:0] REG_ITER  = 2'd2;
   localparam logic [WB_ADR_W-1:0] REG_CTRL  = 2'd3;

   // field positions inside REG_CONF and REG_CTRL
   localparam int CONF_SELA_LSB   = 0;
   localparam int CONF_SELB_LSB   = 4;
   localparam int CONF_SELO_LSB   = 8;
   localparam int CONF_OPCODE_LSB = 12;
   localparam int CTRL_START_BIT  = 0;
   localparam int CTRL_BUSY_BIT   = 0;
   localparam int CTRL_DONE_BIT   = 1;

endpackage

//--- hdl/flow_inmux.sv
`timescale 1ns/1ns

module flow_inmux #(
   parameter int DATA_W  = flow_pkg::DEF_DATA_W,
   parameter int N_LANES = flow_pkg::DEF_N_LANES
) (
   input  flow_pkg::lane_sel_t sel,
   input  flow_pkg::flow_bus_t flow_in,
   output logic [DATA_W-1:0]   data_out
);

   // lane index beyond the bus gives zero
   always_comb begin
      data_out = '0;
      for (int i = 0; i < N_LANES; i++) begin
         if (sel == i) begin
            data_out = flow_in[i][DATA_W-1:0];
         end
      end
   end

endmodule

//--- hdl/mul_pipe.sv
`timescale 1ns/1ns

module mul_pipe #(
   parameter int DATA_W = flow_pkg::DEF_DATA_W
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic signed [DATA_W-1:0]   op_a,
   input  logic signed [DATA_W-1:0]   op_b,
   input  logic                       in_valid,
   input  logic                       in_ld,
   output logic signed [2*DATA_W-1:0] product,
   output logic                       out_valid,
   output logic                       out_ld
);

   localparam int DEPTH = muladd_pkg::PIPE_DEPTH;

   logic signed [DATA_W-1:0] a_s1;
   logic signed [DATA_W-1:0] b_s1;
   logic [DEPTH-1:0]         valid_sr;   // flags ride along with the operands
   logic [DEPTH-1:0]         ld_sr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_sr <= '0;
         ld_sr    <= '0;
      end else begin
         valid_sr <= {valid_sr[DEPTH-2:0], in_valid};
         ld_sr    <= {ld_sr[DEPTH-2:0], in_ld};
      end
   end

   // stage 1 registers operands, stage 2 the product
   always_ff @(posedge clk) begin
      a_s1    <= op_a;
      b_s1    <= op_b;
      product <= a_s1 * b_s1;
   end

   assign out_valid = valid_sr[DEPTH-1];
   assign out_ld    = ld_sr[DEPTH-1];

endmodule

//--- hdl/muladd_datapath.sv
`timescale 1ns/1ns

module muladd_datapath #(
   parameter int DATA_W  = flow_pkg::DEF_DATA_W,
   parameter int N_LANES = flow_pkg::DEF_N_LANES
) (
   input  logic                     clk,
   input  logic                     rst,
   input  flow_pkg::flow_bus_t      flow_in,
   input  muladd_pkg::muladd_conf_t conf,
   input  logic                     issue,
   output logic [DATA_W-1:0]        flow_out,
   output logic                     out_valid
);

   localparam logic [DATA_W-1:0] ZERO_W = '0;

   logic signed [DATA_W-1:0]   op_a;
   logic signed [DATA_W-1:0]   op_b;
   logic [DATA_W-1:0]          op_o;
   logic [DATA_W-1:0]          op_o_q;     // reload lane, one cycle back
   logic signed [2*DATA_W-1:0] product;
   logic                       reload;
   logic [2*DATA_W-1:0]        acc;
   logic [2*DATA_W-1:0]        result;
   logic [2*DATA_W-1:0]        prod_x2;
   logic [2*DATA_W-1:0]        term_hi;
   logic [2*DATA_W-1:0]        term_x2_hi;
   logic [2*DATA_W-1:0]        term_q16;
   logic [2*DATA_W-1:0]        term_low;

   flow_inmux #(.DATA_W(DATA_W), .N_LANES(N_LANES)) i_mux_a (
      .sel      (conf.sela),
      .flow_in  (flow_in),
      .data_out (op_a)
   );

   flow_inmux #(.DATA_W(DATA_W), .N_LANES(N_LANES)) i_mux_b (
      .sel      (conf.selb),
      .flow_in  (flow_in),
      .data_out (op_b)
   );

   flow_inmux #(.DATA_W(DATA_W), .N_LANES(N_LANES)) i_mux_o (
      .sel      (conf.selo),
      .flow_in  (flow_in),
      .data_out (op_o)
   );

   always_ff @(posedge clk) begin
      op_o_q <= op_o;
   end

   mul_pipe #(.DATA_W(DATA_W)) i_mul (
      .clk       (clk),
      .rst       (rst),
      .op_a      (op_a),
      .op_b      (op_b),
      .in_valid  (issue),
      .in_ld     (op_o_q == ZERO_W),
      .product   (product),
      .out_valid (out_valid),
      .out_ld    (reload)
   );

   assign prod_x2    = product <<< 1;
   assign term_hi    = {product[2*DATA_W-1:DATA_W], ZERO_W};
   assign term_x2_hi = {prod_x2[2*DATA_W-1:DATA_W], ZERO_W};
   assign term_q16   = {product[DATA_W+DATA_W/2-1 -: DATA_W], ZERO_W};   // 16Q16 middle
   assign term_low   = {product[DATA_W-1:0], ZERO_W};

   always_comb begin
      case (conf.opcode)
         muladd_pkg::MUL_DIV2:     result = term_hi;
         muladd_pkg::MUL:          result = prod_x2;
         muladd_pkg::MACC_DIV2:    result = reload ? term_hi : acc + term_hi;
         muladd_pkg::MSUB_DIV2:    result = reload ? product : acc - product;
         muladd_pkg::MACC:         result = reload ? term_x2_hi : acc + term_x2_hi;
         muladd_pkg::MACC_16Q16:   result = reload ? term_q16 : acc + term_q16;
         muladd_pkg::MSUB:         result = reload ? prod_x2 : acc - prod_x2;
         muladd_pkg::MUL_LOW:      result = term_low;
         muladd_pkg::MUL_LOW_MACC: result = reload ? term_low : acc + term_low;
         default:                  result = acc + prod_x2;   // plain MACC, never reloads
      endcase
   end

   // accumulator follows the result on valid cycles only
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc <= '0;
      end else if (out_valid) begin
         acc <= result;
      end
   end

   assign flow_out = result[2*DATA_W-1:DATA_W];

endmodule

//--- hdl/run_ctrl.sv
`timescale 1ns/1ns

module run_ctrl (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              start,
   input  muladd_pkg::muladd_conf_t          conf,
   input  logic                              timer_zero,
   output logic                              timer_load,
   output logic [muladd_pkg::PERIOD_W-1:0]   timer_value,
   output logic                              issue,
   output logic                              busy,
   output logic                              done
);

   muladd_pkg::run_state_e state;
   muladd_pkg::run_state_e state_nxt;

   // timer is reloaded on every phase entry
   always_comb begin
      state_nxt   = state;
      timer_load  = 1'b0;
      timer_value = conf.iterations;
      case (state)
         muladd_pkg::IDLE: begin
            if (start) begin
               timer_load = 1'b1;
               if (conf.delay == '0) begin
                  state_nxt = muladd_pkg::RUN;   // no start delay
               end else begin
                  state_nxt   = muladd_pkg::WAIT;
                  timer_value = conf.delay;
               end
            end
         end
         muladd_pkg::WAIT: begin
            if (timer_zero) begin
               state_nxt  = muladd_pkg::RUN;
               timer_load = 1'b1;
            end
         end
         muladd_pkg::RUN: begin
            if (timer_zero) begin
               state_nxt   = muladd_pkg::DRAIN;
               timer_load  = 1'b1;
               timer_value = muladd_pkg::PERIOD_W'(muladd_pkg::PIPE_DEPTH);
            end
         end
         default: begin
            if (timer_zero) state_nxt = muladd_pkg::IDLE;   // pipeline empty
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= muladd_pkg::IDLE;
         done  <= 1'b0;
      end else begin
         state <= state_nxt;
         if (start && state == muladd_pkg::IDLE) begin
            done <= 1'b0;
         end else if (state == muladd_pkg::DRAIN && timer_zero) begin
            done <= 1'b1;   // held until the next start
         end
      end
   end

   assign issue = (state == muladd_pkg::RUN);
   assign busy  = (state != muladd_pkg::IDLE);

endmodule

//--- hdl/period_timer.sv
`timescale 1ns/1ns

module period_timer (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            load,
   input  logic [muladd_pkg::PERIOD_W-1:0] load_value,
   output logic                            zero
);

   logic [muladd_pkg::PERIOD_W-1:0] count;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (load) begin
         count <= load_value;
      end else if (count != '0) begin
         count <= count - 1'b1;   // parks at zero
      end
   end

   // last cycle of a phase is count 1, a zero length behaves as 1
   assign zero = (count[muladd_pkg::PERIOD_W-1:1] == '0);

endmodule

//--- hdl/conf_regs.sv
`timescale 1ns/1ns

module conf_regs (
   input  logic                            clk,
   input  logic                            rst,
   input  muladd_pkg::wb_req_t             wb_req,
   output logic [muladd_pkg::WB_DAT_W-1:0] wb_dat_o,
   output logic                            wb_ack,
   input  logic                            busy,
   input  logic                            done,
   output muladd_pkg::muladd_conf_t        conf,
   output logic                            start
);

   logic                            req;
   logic                            wr;
   logic                            locked;   // run active or starting
   logic [muladd_pkg::WB_DAT_W-1:0] rd_data;

   assign req    = wb_req.cyc && wb_req.stb && !wb_ack;   // one ack per request
   assign wr     = req && wb_req.we;
   assign locked = busy || start;

   always_comb begin
      rd_data = '0;
      case (wb_req.adr)
         muladd_pkg::REG_CONF: begin
            rd_data[muladd_pkg::CONF_SELA_LSB +: flow_pkg::lane_sel_w]   = conf.sela;
            rd_data[muladd_pkg::CONF_SELB_LSB +: flow_pkg::lane_sel_w]   = conf.selb;
            rd_data[muladd_pkg::CONF_SELO_LSB +: flow_pkg::lane_sel_w]   = conf.selo;
            rd_data[muladd_pkg::CONF_OPCODE_LSB +: muladd_pkg::OPCODE_W] = conf.opcode;
         end
         muladd_pkg::REG_DELAY: rd_data[muladd_pkg::PERIOD_W-1:0] = conf.delay;
         muladd_pkg::REG_ITER:  rd_data[muladd_pkg::PERIOD_W-1:0] = conf.iterations;
         muladd_pkg::REG_CTRL: begin
            rd_data[muladd_pkg::CTRL_BUSY_BIT] = busy;
            rd_data[muladd_pkg::CTRL_DONE_BIT] = done;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wb_ack   <= 1'b0;
         wb_dat_o <= '0;
         start    <= 1'b0;
         conf     <= '0;
      end else begin
         wb_ack <= req;
         start  <= wr && !locked && (wb_req.adr == muladd_pkg::REG_CTRL)
                   && wb_req.dat[muladd_pkg::CTRL_START_BIT];
         if (req) wb_dat_o <= rd_data;   // held through the ack cycle
         // config writes while a run is active are acked and dropped
         if (wr && !locked) begin
            case (wb_req.adr)
               muladd_pkg::REG_CONF: begin
                  conf.sela   <= wb_req.dat[muladd_pkg::CONF_SELA_LSB +: flow_pkg::lane_sel_w];
                  conf.selb   <= wb_req.dat[muladd_pkg::CONF_SELB_LSB +: flow_pkg::lane_sel_w];
                  conf.selo   <= wb_req.dat[muladd_pkg::CONF_SELO_LSB +: flow_pkg::lane_sel_w];
                  conf.opcode <= muladd_pkg::opcode_e'(
                                 wb_req.dat[muladd_pkg::CONF_OPCODE_LSB +: muladd_pkg::OPCODE_W]);
               end
               muladd_pkg::REG_DELAY: conf.delay <= wb_req.dat[muladd_pkg::PERIOD_W-1:0];
               muladd_pkg::REG_ITER:  conf.iterations <= wb_req.dat[muladd_pkg::PERIOD_W-1:0];
               default: ;   // REG_CTRL only starts
            endcase
         end
      end
   end

endmodule

//--- hdl/muladd_unit.sv
`timescale 1ns/1ns

module muladd_unit #(
   parameter int DATA_W  = 32,
   parameter int N_LANES = 8
) (
   input  logic                            clk,
   input  logic                            rst,
   input  muladd_pkg::wb_req_t             wb_req,
   output logic [muladd_pkg::WB_DAT_W-1:0] wb_dat_o,
   output logic                            wb_ack,
   input  flow_pkg::flow_bus_t             flow_in,
   output logic [DATA_W-1:0]               flow_out,
   output logic                            out_valid
);

   muladd_pkg::muladd_conf_t        conf;
   logic                            start;
   logic                            busy;
   logic                            done;
   logic                            issue;
   logic                            timer_load;
   logic [muladd_pkg::PERIOD_W-1:0] timer_value;
   logic                            timer_zero;

   conf_regs i_conf_regs (
      .clk      (clk),
      .rst      (rst),
      .wb_req   (wb_req),
      .wb_dat_o (wb_dat_o),
      .wb_ack   (wb_ack),
      .busy     (busy),
      .done     (done),
      .conf     (conf),
      .start    (start)
   );

   run_ctrl i_run_ctrl (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .conf        (conf),
      .timer_zero  (timer_zero),
      .timer_load  (timer_load),
      .timer_value (timer_value),
      .issue       (issue),
      .busy        (busy),
      .done        (done)
   );

   period_timer i_timer (
      .clk        (clk),
      .rst        (rst),
      .load       (timer_load),
      .load_value (timer_value),
      .zero       (timer_zero)
   );

   muladd_datapath #(.DATA_W(DATA_W), .N_LANES(N_LANES)) i_datapath (
      .clk       (clk),
      .rst       (rst),
      .flow_in   (flow_in),
      .conf      (conf),
      .issue     (issue),
      .flow_out  (flow_out),
      .out_valid (out_valid)
   );

endmodule

//--- dv/muladd_unit_asserts.sv
`timescale 1ns/1ns

module muladd_unit_asserts #(
   parameter int DATA_W  = 32,
   parameter int N_LANES = 8
) (
   input logic                clk,
   input logic                rst,
   input muladd_pkg::wb_req_t wb_req,
   input logic [31:0]         wb_dat_o,
   input logic                wb_ack,
   input flow_pkg::flow_bus_t flow_in,
   input logic [DATA_W-1:0]   flow_out,
   input logic                out_valid,
   input logic                issue,
   input logic                busy,
   input logic                done,
   input logic                start
);

   localparam int D = muladd_pkg::PIPE_DEPTH;

   logic        err = 1'b0;
   logic        mism = 1'b0;
   string       err_sig = "";
   logic [31:0] err_exp;
   logic [31:0] err_act;

   logic [31:0] sh_conf, sh_delay, sh_iter;   // last accepted writes
   logic        fresh;                        // no run since reset
   logic [31:0] since, vcount;
   logic signed [DATA_W-1:0] a_sr [D], b_sr [D];
   logic [D-1:0] v_sr, ld_sr;
   logic [DATA_W-1:0] prev_o;
   logic [2*DATA_W-1:0] ref_acc, exp_res, p, p2, lo, q16;
   logic [31:0] rd_exp;

   function automatic logic [DATA_W-1:0] lane(flow_pkg::flow_bus_t bus, logic [31:0] sel);
      return bus[sel[$clog2(N_LANES)-1:0]];
   endfunction

   function automatic logic [2*DATA_W-1:0] upper(logic [2*DATA_W-1:0] x);
      return {x[2*DATA_W-1:DATA_W], {DATA_W{1'b0}}};
   endfunction

   task automatic flag_failure(input string sig);
      err_sig = sig;
      err     = 1'b1;
   endtask

   task automatic record_mismatch(input string sig, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      err_sig = sig;
      err_exp = exp_v;
      err_act = act_v;
      mism    = 1'b1;
      err     = 1'b1;
   endtask

   assign p   = (2*DATA_W)'($signed(a_sr[D-1]) * $signed(b_sr[D-1]));
   assign p2  = p << 1;
   assign lo  = {p[DATA_W-1:0], {DATA_W{1'b0}}};
   assign q16 = {p[DATA_W+DATA_W/2-1 -: DATA_W], {DATA_W{1'b0}}};

   always_comb begin
      case (sh_conf[15:12])
         4'd0: exp_res = upper(p);
         4'd1: exp_res = p2;
         4'd2: exp_res = ld_sr[D-1] ? upper(p) : ref_acc + upper(p);
         4'd3: exp_res = ld_sr[D-1] ? p : ref_acc - p;
         4'd4: exp_res = ld_sr[D-1] ? upper(p2) : ref_acc + upper(p2);
         4'd5: exp_res = ld_sr[D-1] ? q16 : ref_acc + q16;
         4'd6: exp_res = ld_sr[D-1] ? p2 : ref_acc - p2;
         4'd7: exp_res = lo;
         4'd8: exp_res = ld_sr[D-1] ? lo : ref_acc + lo;
         default: exp_res = ref_acc + p2;   // never reloads
      endcase
      case (wb_req.adr)
         2'd0: rd_exp = sh_conf;
         2'd1: rd_exp = sh_delay;
         default: rd_exp = sh_iter;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         {sh_conf, sh_delay, sh_iter} <= '0;
         {since, vcount, v_sr, ld_sr, ref_acc, prev_o} <= '0;
         fresh <= 1'b1;
      end else begin
         if (wb_req.cyc && wb_req.stb && wb_req.we && !wb_ack && !busy && !start) begin
            case (wb_req.adr)
               2'd0: sh_conf <= wb_req.dat & 32'h0000_f777;
               2'd1: sh_delay <= {16'h0, wb_req.dat[15:0]};
               2'd2: sh_iter <= {16'h0, wb_req.dat[15:0]};
               default: ;
            endcase
         end
         since  <= start ? 32'd1 : since + 1;
         vcount <= out_valid ? vcount + 1 : '0;
         if (start) fresh <= 1'b0;
         prev_o <= lane(flow_in, sh_conf[10:8]);
         a_sr[0] <= lane(flow_in, sh_conf[2:0]);
         b_sr[0] <= lane(flow_in, sh_conf[6:4]);
         for (int i = 1; i < D; i++) begin
            a_sr[i] <= a_sr[i-1];
            b_sr[i] <= b_sr[i-1];
         end
         v_sr  <= {v_sr[D-2:0], issue};
         ld_sr <= {ld_sr[D-2:0], prev_o == '0};
         if (v_sr[D-1]) ref_acc <= exp_res;
      end
   end

   ack_follows_req: assert property (@(posedge clk) disable iff (rst)
      (wb_req.cyc && wb_req.stb && !wb_ack) |=> wb_ack)
      else begin
         flag_failure("wb_ack late");
         $error("ack missing");
      end

   ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
      else begin
         flag_failure("wb_ack too long");
         $error("ack held");
      end

   readback: assert property (@(posedge clk) disable iff (rst)
      (wb_ack && !wb_req.we && wb_req.adr != 2'd3) |-> wb_dat_o == rd_exp)
      else begin
         record_mismatch("wb_dat_o", $sampled(rd_exp), $sampled(wb_dat_o));
         $error("readback wrong");
      end

   valid_timing: assert property (@(posedge clk) disable iff (rst) out_valid == v_sr[D-1])
      else begin
         flag_failure("out_valid out of step");
         $error("valid wrong");
      end

   result: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> flow_out == exp_res[2*DATA_W-1:DATA_W])
      else begin
         record_mismatch("flow_out", $sampled(exp_res[2*DATA_W-1:DATA_W]),
                         $sampled(flow_out));
         $error("result wrong");
      end

   first_result: assert property (@(posedge clk) disable iff (rst)
      $rose(out_valid) |-> since == sh_delay + 1 + D)
      else begin
         flag_failure("out_valid start delay");
         $error("late result");
      end

   valid_length: assert property (@(posedge clk) disable iff (rst)
      $fell(out_valid) |-> (vcount == sh_iter) && $rose(done))
      else begin
         flag_failure("run length or done");
         $error("bad run end");
      end

   reset_quiet: assert property (@(posedge clk)
      rst && $past(rst) |-> !wb_ack && !out_valid && !busy && !done)
      else begin
         flag_failure("outputs during reset");
         $error("not quiet");
      end

   status_after_reset: assert property (@(posedge clk) disable iff (rst)
      (wb_ack && !wb_req.we && wb_req.adr == 2'd3 && fresh) |-> wb_dat_o[1:0] == 2'b00)
      else begin
         flag_failure("status after reset");
         $error("status set");
      end

endmodule

bind muladd_unit muladd_unit_asserts #(.DATA_W(DATA_W), .N_LANES(N_LANES)) i_asserts (
   .clk       (clk),
   .rst       (rst),
   .wb_req    (wb_req),
   .wb_dat_o  (wb_dat_o),
   .wb_ack    (wb_ack),
   .flow_in   (flow_in),
   .flow_out  (flow_out),
   .out_valid (out_valid),
   .issue     (issue),
   .busy      (busy),
   .done      (done),
   .start     (start)
);

//--- dv/tb_muladd_unit.sv
`timescale 1ns/1ns

module tb_muladd_unit;

   localparam int N_RUNS    = 11;
   localparam int MAX_DELAY = 3;
   localparam int MAX_ITER  = 12;
   localparam int LIMIT     = (N_RUNS * (MAX_DELAY + MAX_ITER + 40)) * 2;

   logic                            clk;
   logic                            rst;
   muladd_pkg::wb_req_t             wb_req;
   logic [muladd_pkg::WB_DAT_W-1:0] wb_dat_o;
   logic                            wb_ack;
   flow_pkg::flow_bus_t             flow_in;
   logic [31:0]                     flow_out;
   logic                            out_valid;

   logic        force_o;   // drop zeros onto the reload lane
   int          o_lane;
   int          cycles;
   logic [31:0] rd;

   muladd_unit #(.DATA_W(32), .N_LANES(8)) i_dut (
      .clk       (clk),
      .rst       (rst),
      .wb_req    (wb_req),
      .wb_dat_o  (wb_dat_o),
      .wb_ack    (wb_ack),
      .flow_in   (flow_in),
      .flow_out  (flow_out),
      .out_valid (out_valid)
   );

   always #2 clk = ~clk;

   // random lanes every cycle
   initial begin
      void'($urandom(37));
      forever begin
         @(negedge clk);
         for (int i = 0; i < 8; i++) flow_in[i] = $urandom;
         if (force_o && ($urandom % 3 == 0)) flow_in[o_lane] = '0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("Test failures found");
         $display("timeout: run did not finish");
         $fatal(1);
      end
   end

   // first failed assertion ends the run
   always @(negedge clk) begin
      if (i_dut.i_asserts.err) begin
         $display("Test failures found");
         if (i_dut.i_asserts.mism) begin
            $display("Mismatch %s expected %h actual %h", i_dut.i_asserts.err_sig,
                     i_dut.i_asserts.err_exp, i_dut.i_asserts.err_act);
         end else begin
            $display("assertion failed on %s", i_dut.i_asserts.err_sig);
         end
         $fatal(1);
      end
   end

   task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                            output logic [31:0] q);
      @(negedge clk);
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
      do @(posedge clk); while (!wb_ack);
      q = wb_dat_o;
      @(negedge clk);
      wb_req = '0;
   endtask

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
      logic [31:0] q;
      wb_access(1'b1, adr, dat, q);
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [31:0] q);
      wb_access(1'b0, adr, '0, q);
   endtask

   task automatic run_op(input logic [3:0] op, input int sa, input int sb, input int so,
                         input int dly, input int iter, input logic zeros, input logic poke);
      logic [31:0] q;
      force_o = zeros;
      o_lane  = so;
      wb_write(muladd_pkg::REG_CONF, 32'(sa) | (32'(sb) << 4) | (32'(so) << 8) | (32'(op) << 12));
      wb_write(muladd_pkg::REG_DELAY, 32'(dly));
      wb_write(muladd_pkg::REG_ITER, 32'(iter));
      wb_read(muladd_pkg::REG_CONF, q);
      wb_read(muladd_pkg::REG_DELAY, q);
      wb_read(muladd_pkg::REG_ITER, q);
      wb_write(muladd_pkg::REG_CTRL, 32'h1);
      if (poke) begin
         // writes and a second start while busy
         wb_write(muladd_pkg::REG_CONF, 32'h0000_7345);
         wb_write(muladd_pkg::REG_ITER, 32'h0000_0002);
         wb_write(muladd_pkg::REG_CTRL, 32'h1);
         wb_read(muladd_pkg::REG_CONF, q);
      end
      do wb_read(muladd_pkg::REG_CTRL, q); while (!q[muladd_pkg::CTRL_DONE_BIT]);
      force_o = 1'b0;
   endtask

   initial begin
      clk     = 1'b0;
      rst     = 1'b1;
      wb_req  = '0;
      flow_in = '0;
      force_o = 1'b0;
      o_lane  = 0;
      cycles  = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      wb_read(muladd_pkg::REG_CTRL, rd);   // status right after reset
      run_op(4'd0, 0, 1, 2, 0, 3, 1'b0, 1'b0);
      run_op(4'd1, 3, 4, 5, 1, 4, 1'b0, 1'b0);
      run_op(4'd2, 1, 2, 7, 2, 8, 1'b1, 1'b0);
      run_op(4'd3, 5, 6, 0, 3, 8, 1'b1, 1'b0);
      run_op(4'd4, 2, 2, 3, 1, MAX_ITER, 1'b1, 1'b1);
      run_op(4'd5, 7, 0, 1, 0, 10, 1'b1, 1'b0);
      run_op(4'd6, 4, 3, 6, 2, 9, 1'b1, 1'b0);
      run_op(4'd7, 6, 1, 4, 1, 5, 1'b0, 1'b0);
      run_op(4'd8, 0, 7, 5, 3, 10, 1'b1, 1'b0);
      run_op(4'd9, 1, 5, 2, 0, 8, 1'b1, 1'b0);
      run_op(4'hc, 3, 3, 4, 2, 7, 1'b1, 1'b0);   // unused code, plain MACC
      repeat (4) @(negedge clk);
      if (i_dut.i_asserts.err) begin
         $display("Test failures found");
         $fatal(1);
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

//--- filelist.f
hdl/flow_pkg.sv
hdl/muladd_pkg.sv
hdl/flow_inmux.sv
hdl/mul_pipe.sv
hdl/muladd_datapath.sv
hdl/run_ctrl.sv
hdl/period_timer.sv
hdl/conf_regs.sv
hdl/muladd_unit.sv
dv/muladd_unit_asserts.sv
dv/tb_muladd_unit.sv
